//--- src/surf5_ctrl_pkg.sv
package surf5_ctrl_pkg;

	// Control bus widths.
	localparam int wb_adr_w = 20;
	localparam int wb_dat_w = 32;
	localparam int wb_sel_w = 4;

	// Upper address nibble picks the region.
	localparam int region_w = 4;
	// Byte offset bits inside one region.
	localparam int ofs_w = wb_adr_w - region_w;

	// Address map, by upper nibble.
	localparam logic [region_w-1:0] region_id_ctrl = 4'h0;
	localparam logic [region_w-1:0] region_ram = 4'h2;

	// Identification slave register offsets (byte addresses).
	localparam logic [ofs_w-1:0] reg_version = 16'h0000;
	localparam logic [ofs_w-1:0] reg_ident = 16'h0004;
	localparam logic [ofs_w-1:0] reg_led = 16'h0008;
	localparam logic [ofs_w-1:0] reg_irq_status = 16'h000C;
	localparam logic [ofs_w-1:0] reg_irq_mask = 16'h0010;

	// Board identifier, ASCII "SURF".
	localparam logic [wb_dat_w-1:0] board_ident = 32'h5355_5246;

	// Interrupt sources and LED outputs.
	localparam int irq_w = 31;
	localparam int led_w = 4;

	// Debug trace word.
	// Data, address, select, then cyc, stb, we, ack, err, rty.
	localparam int trace_w = 62;

	// Version word fields, most significant first.
	typedef struct packed {
		logic [3:0] boardrev;
		logic [3:0] month;
		logic [7:0] day;
		logic [3:0] major;
		logic [3:0] minor;
		logic [7:0] revision;
	} version_fields_t;

	// Version word: built from fields, read back as a raw word.
	typedef union packed {
		logic [wb_dat_w-1:0] raw;
		version_fields_t f;
	} version_u;

endpackage

//--- src/wbc_intercon.sv
module wbc_intercon import surf5_ctrl_pkg::*; (
	input  logic sys_clk,
	input  logic rst_i,
	// Master request.
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic [wb_adr_w-1:0] wb_adr_i,
	// Master response.
	output logic [wb_dat_w-1:0] m_dat_o,
	output logic m_ack_o,
	output logic m_err_o,
	// Identification slave.
	output logic id_stb_o,
	input  logic [wb_dat_w-1:0] id_dat_i,
	input  logic id_ack_i,
	// Sample RAM slave.
	output logic ram_stb_o,
	input  logic [wb_dat_w-1:0] ram_dat_i,
	input  logic ram_ack_i
);

	// Region select from the top nibble.
	logic [region_w-1:0] region;
	logic hit_id;
	logic hit_ram;
	logic hit_none;
	// Active request this cycle.
	logic access;
	// Error responder state.
	logic err_q;
	// Qualified slave acks.
	logic id_resp;
	logic ram_resp;

	assign region = wb_adr_i[wb_adr_w-1 -: region_w];
	assign access = wb_cyc_i && wb_stb_i;

	// Address decode.
	// The LAB4 control region and all spare nibbles fall to the error path.
	assign hit_id = (region == region_id_ctrl);
	assign hit_ram = (region == region_ram);
	assign hit_none = !hit_id && !hit_ram;

	// One strobe per slave, only on a region match.
	assign id_stb_o = wb_stb_i && hit_id;
	assign ram_stb_o = wb_stb_i && hit_ram;

	// Error responder.
	// Same one-cycle timing as a slave ack, and it
	// does not fire twice while stb is still high.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= access && hit_none && !err_q;
		end
	end

	assign m_err_o = err_q;

	// Master holds the address until ack, so
	// the current decode still picks the answering slave.
	assign id_resp = hit_id && id_ack_i;
	assign ram_resp = hit_ram && ram_ack_i;
	assign m_ack_o = id_resp || ram_resp;

	// Read data returns only in the ack cycle.
	// Zero otherwise.
	always_comb begin
		if (id_resp) begin
			m_dat_o = id_dat_i;
		end else if (ram_resp) begin
			m_dat_o = ram_dat_i;
		end else begin
			m_dat_o = '0;
		end
	end

endmodule

//--- src/surf5_id_ctrl.sv
module surf5_id_ctrl import surf5_ctrl_pkg::*; #(
	parameter version_u VERSION = '0
) (
	input  logic sys_clk,
	input  logic rst_i,
	// Slave port.
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [ofs_w-1:0] adr_i,
	input  logic [wb_sel_w-1:0] sel_i,
	input  logic [wb_dat_w-1:0] dat_i,
	output logic [wb_dat_w-1:0] dat_o,
	output logic ack_o,
	// Interrupts.
	input  logic [irq_w-1:0] irq_src_i,
	output logic irq_o,
	// LEDs.
	output logic [led_w-1:0] led_o
);

	// Word address within the region.
	logic [ofs_w-3:0] word_adr;
	// New access starts this cycle.
	logic start;
	logic ack_q;
	logic [wb_dat_w-1:0] rd_d;
	logic [wb_dat_w-1:0] rd_q;
	// Control registers.
	logic [led_w-1:0] led_q;
	logic [irq_w-1:0] mask_q;
	logic irq_q;

	assign word_adr = adr_i[ofs_w-1:2];
	assign start = cyc_i && stb_i && !ack_q;

	// Read mux.
	// Unused offsets read zero.
	always_comb begin
		rd_d = '0;
		case (word_adr)
			reg_version[ofs_w-1:2]: rd_d = VERSION.raw;
			reg_ident[ofs_w-1:2]: rd_d = board_ident;
			reg_led[ofs_w-1:2]: rd_d[led_w-1:0] = led_q;
			reg_irq_status[ofs_w-1:2]: rd_d[irq_w-1:0] = irq_src_i;
			reg_irq_mask[ofs_w-1:2]: rd_d[irq_w-1:0] = mask_q;
			default: rd_d = '0;
		endcase
	end

	// Single-cycle ack.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= start;
		end
	end

	// Read word is captured on the edge that raises ack.
	always_ff @(posedge sys_clk) begin
		if (start) begin
			rd_q <= rd_d;
		end
	end

	// Register writes.
	// Take effect on the same edge as the ack.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			led_q <= '0;
			mask_q <= '0;
		end else if (start && we_i) begin
			// LEDs live in the low byte.
			if (word_adr == reg_led[ofs_w-1:2] && sel_i[0]) begin
				led_q <= dat_i[led_w-1:0];
			end
			// Mask is byte enabled over its full width.
			if (word_adr == reg_irq_mask[ofs_w-1:2]) begin
				for (int i = 0; i < irq_w; i++) begin
					if (sel_i[i/8]) begin
						mask_q[i] <= dat_i[i];
					end
				end
			end
		end
	end

	// Masked interrupt request, one cycle behind.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= |(irq_src_i & mask_q);
		end
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;
	assign led_o = led_q;
	assign irq_o = irq_q;

endmodule

//--- src/sample_ram.sv
module sample_ram import surf5_ctrl_pkg::*; #(
	parameter int RAM_ADDR_W = 10
) (
	input  logic sys_clk,
	input  logic rst_i,
	// Slave port.
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [RAM_ADDR_W-1:0] adr_i,
	input  logic [wb_sel_w-1:0] sel_i,
	input  logic [wb_dat_w-1:0] dat_i,
	output logic [wb_dat_w-1:0] dat_o,
	output logic ack_o
);

	localparam int depth = 2 ** RAM_ADDR_W;

	// Must fit in the 64 kB region.
	if (RAM_ADDR_W > ofs_w - 2) begin : g_size_check
		$error("sample_ram: RAM_ADDR_W too large for the region");
	end

	// Storage, one 32-bit word per address.
	logic [wb_dat_w-1:0] mem [depth];
	logic [wb_dat_w-1:0] rd_q;
	logic ack_q;
	logic start;

	assign start = cyc_i && stb_i && !ack_q;

	// Ack one cycle after the strobe.
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= start;
		end
	end

	// Single port with byte-enabled writes.
	// A read sees the word as it was before this access.
	always_ff @(posedge sys_clk) begin
		if (start) begin
			rd_q <= mem[adr_i];
			if (we_i) begin
				for (int b = 0; b < wb_sel_w; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end
		end
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

endmodule

//--- src/wbc_bus_trace.sv
module wbc_bus_trace import surf5_ctrl_pkg::*; (
	input  logic sys_clk,
	input  logic rst_i,
	// Master-side bus, observed only.
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [wb_adr_w-1:0] adr_i,
	input  logic [wb_sel_w-1:0] sel_i,
	input  logic [wb_dat_w-1:0] m_dat_i,
	input  logic [wb_dat_w-1:0] s_dat_i,
	input  logic ack_i,
	input  logic err_i,
	// Snapshot, one cycle late.
	output logic [trace_w-1:0] trace_o
);

	// Field positions in the trace word.
	localparam int adr_lsb = wb_dat_w;
	localparam int sel_lsb = adr_lsb + wb_adr_w;
	localparam int cyc_bit = sel_lsb + wb_sel_w;
	localparam int stb_bit = cyc_bit + 1;
	localparam int we_bit = cyc_bit + 2;
	localparam int ack_bit = cyc_bit + 3;
	localparam int err_bit = cyc_bit + 4;
	localparam int rty_bit = cyc_bit + 5;

	logic [trace_w-1:0] trace_d;
	logic [trace_w-1:0] trace_q;

	// Pack the bus into the trace layout.
	always_comb begin
		// Write data on writes, returned data on reads.
		trace_d[0 +: wb_dat_w] = we_i ? m_dat_i : s_dat_i;
		trace_d[adr_lsb +: wb_adr_w] = adr_i;
		trace_d[sel_lsb +: wb_sel_w] = sel_i;
		trace_d[cyc_bit] = cyc_i;
		trace_d[stb_bit] = stb_i;
		trace_d[we_bit] = we_i;
		trace_d[ack_bit] = ack_i;
		trace_d[err_bit] = err_i;
		// No retry on this bus.
		trace_d[rty_bit] = 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			trace_q <= '0;
		end else begin
			trace_q <= trace_d;
		end
	end

	assign trace_o = trace_q;

endmodule

//--- src/surf5_ctrl_top.sv
module surf5_ctrl_top import surf5_ctrl_pkg::*; #(
	parameter logic [3:0] BOARDREV = 4'd1,
	parameter logic [3:0] MONTH = 4'd10,
	parameter logic [7:0] DAY = 8'd5,
	parameter logic [3:0] MAJOR = 4'd0,
	parameter logic [3:0] MINOR = 4'd6,
	parameter logic [7:0] REVISION = 8'd6,
	parameter int RAM_ADDR_W = 10
) (
	input  logic sys_clk,
	input  logic rst_i,
	// Master side of the control bus.
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [wb_adr_w-1:0] wb_adr_i,
	input  logic [wb_sel_w-1:0] wb_sel_i,
	input  logic [wb_dat_w-1:0] wb_dat_i,
	output logic [wb_dat_w-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	// Interrupt sources and request.
	input  logic [irq_w-1:0] irq_src_i,
	output logic irq_o,
	// Board LEDs.
	output logic [led_w-1:0] led_o,
	// Debug trace of the master-side bus.
	output logic [trace_w-1:0] trace_o
);

	// Firmware version, assembled from its fields.
	localparam version_fields_t version_fields = '{
		boardrev: BOARDREV,
		month: MONTH,
		day: DAY,
		major: MAJOR,
		minor: MINOR,
		revision: REVISION
	};
	localparam version_u version_word = version_u'(version_fields);

	// Slave strobes and responses.
	logic id_stb;
	logic id_ack;
	logic [wb_dat_w-1:0] id_dat;
	logic ram_stb;
	logic ram_ack;
	logic [wb_dat_w-1:0] ram_dat;

	wbc_intercon u_wbc_intercon (
		.sys_clk(sys_clk),
		.rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_adr_i(wb_adr_i),
		.m_dat_o(wb_dat_o),
		.m_ack_o(wb_ack_o),
		.m_err_o(wb_err_o),
		.id_stb_o(id_stb),
		.id_dat_i(id_dat),
		.id_ack_i(id_ack),
		.ram_stb_o(ram_stb),
		.ram_dat_i(ram_dat),
		.ram_ack_i(ram_ack)
	);

	// Identification slave sees only the offset within its region.
	surf5_id_ctrl #(.VERSION(version_word)) u_surf5_id_ctrl (
		.sys_clk(sys_clk),
		.rst_i(rst_i),
		.cyc_i(wb_cyc_i),
		.stb_i(id_stb),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i[ofs_w-1:0]),
		.sel_i(wb_sel_i),
		.dat_i(wb_dat_i),
		.irq_src_i(irq_src_i),
		.dat_o(id_dat),
		.ack_o(id_ack),
		.led_o(led_o),
		.irq_o(irq_o)
	);

	// RAM takes word address bits, so the region wraps.
	sample_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_sample_ram (
		.sys_clk(sys_clk),
		.rst_i(rst_i),
		.cyc_i(wb_cyc_i),
		.stb_i(ram_stb),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i[RAM_ADDR_W+1:2]),
		.sel_i(wb_sel_i),
		.dat_i(wb_dat_i),
		.dat_o(ram_dat),
		.ack_o(ram_ack)
	);

	wbc_bus_trace u_wbc_bus_trace (
		.sys_clk(sys_clk),
		.rst_i(rst_i),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i),
		.sel_i(wb_sel_i),
		.m_dat_i(wb_dat_i),
		.s_dat_i(wb_dat_o),
		.ack_i(wb_ack_o),
		.err_i(wb_err_o),
		.trace_o(trace_o)
	);

endmodule

//--- bench/surf5_ctrl_properties.sv
module surf5_ctrl_properties import surf5_ctrl_pkg::*; (
	input logic sys_clk,
	input logic rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [wb_adr_w-1:0] wb_adr_i,
	input logic [wb_sel_w-1:0] wb_sel_i,
	input logic [wb_dat_w-1:0] wb_dat_i,
	input logic [wb_dat_w-1:0] wb_dat_o,
	input logic wb_ack_o,
	input logic wb_err_o,
	input logic [irq_w-1:0] irq_src_i,
	input logic irq_o,
	input logic [led_w-1:0] led_o,
	input logic [trace_w-1:0] trace_o,
	// Interrupt mask register inside the identification slave.
	input logic [irq_w-1:0] mask_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertion count that the testbench watches.
	int n_fail = 0;
	logic resp;
	logic req_start;
	logic mapped;
	logic [trace_w-1:0] bus_now;

	assign resp = wb_ack_o || wb_err_o;
	// First cycle of a strobe before any response.
	assign req_start = wb_cyc_i && wb_stb_i && !resp;
	assign mapped = (wb_adr_i[wb_adr_w-1 -: 4] == region_id_ctrl)
		|| (wb_adr_i[wb_adr_w-1 -: 4] == region_ram);
	// Trace layout from the top is rty, err, ack, we, stb, cyc, sel, adr and data.
	assign bus_now = {1'b0, wb_err_o, wb_ack_o, wb_we_i, wb_stb_i, wb_cyc_i,
		wb_sel_i, wb_adr_i, wb_we_i ? wb_dat_i : wb_dat_o};

	a_resp_after_start: assert property (@(posedge sys_clk) disable iff (rst_i)
		req_start |=> resp)
		else begin
			n_fail++;
			$error("no response one cycle after strobe");
		end
	a_resp_needs_start: assert property (@(posedge sys_clk) disable iff (rst_i)
		resp |-> $past(req_start))
		else begin
			n_fail++;
			$error("response without a strobe start");
		end
	a_one_response: assert property (@(posedge sys_clk) !(wb_ack_o && wb_err_o))
		else begin
			n_fail++;
			$error("ack and err high together");
		end
	a_err_region: assert property (@(posedge sys_clk) disable iff (rst_i)
		wb_err_o |-> !mapped)
		else begin
			n_fail++;
			$error("err on a mapped region");
		end
	a_ack_region: assert property (@(posedge sys_clk) disable iff (rst_i)
		wb_ack_o |-> mapped)
		else begin
			n_fail++;
			$error("ack on an unmapped region");
		end
	// Read data is zero outside the ack cycle.
	a_dat_idle: assert property (@(posedge sys_clk) disable iff (rst_i)
		!wb_ack_o |-> wb_dat_o == '0)
		else begin
			n_fail++;
			$error("read data not zero outside the ack cycle");
		end
	// Trace is the bus of the previous cycle.
	a_trace: assert property (@(posedge sys_clk) disable iff (rst_i)
		!$past(rst_i) |-> trace_o == $past(bus_now))
		else begin
			n_fail++;
			$error("trace does not match the past bus");
		end
	a_irq: assert property (@(posedge sys_clk) disable iff (rst_i)
		!$past(rst_i) |-> irq_o == $past(|(irq_src_i & mask_i)))
		else begin
			n_fail++;
			$error("irq does not follow the masked sources");
		end
	// Outputs come out of reset quiet.
	a_quiet: assert property (@(posedge sys_clk) $past(rst_i) |-> !wb_ack_o && !wb_err_o
		&& !irq_o && led_o == '0 && trace_o == '0 && mask_i == '0)
		else begin
			n_fail++;
			$error("outputs not quiet after reset");
		end

endmodule

//--- bench/surf5_ctrl_tb.sv
module surf5_ctrl_tb import surf5_ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic sys_clk;
	logic rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [wb_adr_w-1:0] wb_adr_i;
	logic [wb_sel_w-1:0] wb_sel_i;
	logic [wb_dat_w-1:0] wb_dat_i;
	logic [wb_dat_w-1:0] wb_dat_o;
	logic wb_ack_o;
	logic wb_err_o;
	logic [irq_w-1:0] irq_src_i;
	logic irq_o;
	logic [led_w-1:0] led_o;
	logic [trace_w-1:0] trace_o;
	// Stimulus state and last bus response.
	logic [31:0] lfsr;
	logic got_ack;
	logic got_err;
	logic [31:0] rd_data;
	logic [31:0] ram_model [int];
	logic [9:0] ram_adr [16];

	surf5_ctrl_top u_surf5_ctrl_top (.*);

	bind surf5_ctrl_top surf5_ctrl_properties u_props (.*, .mask_i(u_surf5_id_ctrl.mask_q));

	always #20 sys_clk = ~sys_clk;

	task automatic stop_fail(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			stop_fail($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// One classic single transfer with the response sampled at the falling edge.
	task automatic bus_access(input logic we, input logic [19:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		int n;
		@(posedge sys_clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i <= we;
		wb_adr_i <= adr;
		wb_sel_i <= sel;
		wb_dat_i <= dat;
		got_ack = 1'b0;
		got_err = 1'b0;
		for (n = 0; n < 16 && !(got_ack || got_err); n++) begin
			@(negedge sys_clk);
			got_ack = wb_ack_o;
			got_err = wb_err_o;
			rd_data = wb_dat_o;
		end
		if (!(got_ack || got_err)) begin
			stop_fail($sformatf("no bus response at address %h", adr));
		end else begin
			@(posedge sys_clk);
			wb_cyc_i <= 1'b0;
			wb_stb_i <= 1'b0;
			wb_we_i <= 1'b0;
		end
	endtask

	task automatic write_word(input logic [19:0] adr, input logic [3:0] sel, input logic [31:0] dat);
		bus_access(1'b1, adr, sel, dat);
		if (!got_ack) begin
			stop_fail($sformatf("write to %h was not acknowledged", adr));
		end
	endtask

	task automatic read_check(input string name, input logic [19:0] adr, input logic [31:0] exp);
		bus_access(1'b0, adr, 4'hF, 32'h0);
		check_val({name, " ack"}, 32'd1, {31'd0, got_ack});
		check_val(name, exp, rd_data);
	endtask

	// Any failed assertion ends the run at once.
	always @(negedge sys_clk) begin
		if (u_surf5_ctrl_top.u_props.n_fail != 0) begin
			stop_fail("a bus protocol assertion failed");
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] m;
		logic [31:0] v;
		sys_clk = 1'b0;
		rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_sel_i = '0;
		wb_dat_i = '0;
		irq_src_i = '0;
		lfsr = 32'h2edf7bea;
		repeat (3) @(posedge sys_clk);
		rst_i <= 1'b0;

		// Identification region.
		read_check("version", 20'h00000, 32'h1A050606);
		read_check("ident", 20'h00004, 32'h53555246);
		read_check("spare offset", 20'h00014, 32'h0);
		read_check("last offset", 20'h0FFFC, 32'h0);

		// LEDs follow byte 0 only.
		write_word(20'h00008, 4'b0001, 32'hFFFFFF05);
		check_val("led_o write", 32'h5, led_o);
		write_word(20'h00008, 4'b1110, 32'h0000000A);
		check_val("led_o masked write", 32'h5, led_o);
		read_check("led read", 20'h00008, 32'h5);
		write_word(20'h00008, 4'b1111, 32'h000000FA);
		read_check("led full write", 20'h00008, 32'hA);

		// RAM at random words is read back through aliased addresses.
		for (int k = 0; k < 16; k++) begin
			rand_bits(10, a);
			rand_bits(32, d);
			ram_adr[k] = a[9:0];
			ram_model[a] = d;
			write_word({4'h2, 4'h0, a[9:0], 2'b00}, 4'hF, d);
		end
		for (int k = 0; k < 16; k++) begin
			rand_bits(4, v);
			read_check("ram readback", {4'h2, v[3:0], ram_adr[k], 2'b00}, ram_model[ram_adr[k]]);
		end
		rand_bits(32, d);
		write_word({4'h2, 4'h0, ram_adr[0], 2'b00}, 4'b0101, d);
		m = ram_model[ram_adr[0]];
		m = {m[31:24], d[23:16], m[15:8], d[7:0]};
		read_check("ram partial write", {4'h2, 4'h0, ram_adr[0], 2'b00}, m);

		// Unmapped nibbles end in err with reads and writes alternating.
		for (int k = 1; k < 16; k++) begin
			if (k != 2) begin
				rand_bits(16, a);
				bus_access(k[0], {k[3:0], a[15:0]}, 4'hF, a);
				check_val("unmapped err and ack", 32'h2, {30'd0, got_err, got_ack});
			end
		end

		// Interrupt mask and sources start with a zero mask.
		for (int k = 0; k < 8; k++) begin
			rand_bits(31, m);
			if (k == 0) begin
				m = '0;
			end
			rand_bits(31, v);
			write_word(20'h00010, 4'hF, m);
			@(posedge sys_clk);
			irq_src_i <= v[30:0];
			read_check("irq mask", 20'h00010, m);
			read_check("irq status", 20'h0000C, v);
		end
		repeat (2) @(posedge sys_clk);

		if (u_surf5_ctrl_top.u_props.n_fail == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			stop_fail("an assertion failed during the run");
		end
	end

endmodule

//--- surf5_ctrl.f
src/surf5_ctrl_pkg.sv
src/wbc_intercon.sv
src/surf5_id_ctrl.sv
src/sample_ram.sv
src/wbc_bus_trace.sv
src/surf5_ctrl_top.sv
bench/surf5_ctrl_properties.sv
bench/surf5_ctrl_tb.sv
